//--- common/axi_mux_pkg.sv
/* Widths shared by the write mux and its bench. The master ID width is not here;
   each module derives it as SLV_ID_WIDTH plus the clog2 of its port count */
package axi_mux_pkg;

  // ------------------------------------------------------------------
  // Channel widths
  // ------------------------------------------------------------------
  localparam int unsigned SLV_ID_WIDTH = 4;   // ID width seen at each upstream port
  localparam int unsigned ADDR_WIDTH   = 32;  // AW address
  localparam int unsigned DATA_WIDTH   = 32;  // W data, no strobes carried

  // ------------------------------------------------------------------
  // B response codes
  // ------------------------------------------------------------------
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,  // Exclusive access success
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11   // No slave at this address
  } axi_resp_e;

endpackage

//--- design/spill_register.sv
/* Two-entry register slice. valid_o, data_o and ready_o all come from flops,
   so neither path is combinational through this block */
`timescale 1ns/1ps

module spill_register #(
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  logic [WIDTH-1:0] slot_q [2];
  logic [1:0]       full_q;
  logic             rd_ptr_q;   // Slot that is presented downstream
  logic             wr_sel;
  logic             push;
  logic             pop;

  assign valid_o = full_q[rd_ptr_q];
  assign data_o  = slot_q[rd_ptr_q];
  assign ready_o = ~&full_q;    // Low only with both slots taken

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // Fill the head slot when empty, else the one behind it
  assign wr_sel = full_q[rd_ptr_q] ? ~rd_ptr_q : rd_ptr_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q   <= '0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (pop) begin
        full_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q         <= ~rd_ptr_q;
      end
      if (push) begin
        full_q[wr_sel] <= 1'b1;  // Never the slot being popped
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_q[wr_sel] <= data_i;
    end
  end

  // Downstream sees a stable offer until it takes it
  a_out_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("spill_register output changed while stalled");

endmodule

//--- design/aw_arbiter.sv
/* Round-robin AW arbiter for at least 2 ports. Upstream valid must stay high
   until ready; a stalled AW is locked so the W route is pushed once per AW */
`timescale 1ns/1ps

module aw_arbiter import axi_mux_pkg::*; #(
  parameter  int unsigned NUM_PORTS = 4,
  localparam int unsigned IDX_W     = $clog2(NUM_PORTS),
  localparam int unsigned MST_ID_W  = SLV_ID_WIDTH + IDX_W
) (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic [NUM_PORTS-1:0]                     slv_aw_valid_i,
  input  logic [NUM_PORTS-1:0][SLV_ID_WIDTH-1:0]   slv_aw_id_i,
  input  logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0]     slv_aw_addr_i,
  output logic [NUM_PORTS-1:0]                     slv_aw_ready_o,
  output logic                                     aw_valid_o,
  input  logic                                     aw_ready_i,
  output logic [MST_ID_W-1:0]                      aw_id_o,
  output logic [ADDR_WIDTH-1:0]                    aw_addr_o,
  input  logic                                     fifo_full_i,
  output logic                                     fifo_push_o,
  output logic [IDX_W-1:0]                         fifo_idx_o
);

  typedef enum logic {
    AW_IDLE,
    AW_LOCKED   // AW issued and pushed, waiting for the spill stage
  } aw_state_e;

  aw_state_e        state_q, state_d;
  logic [IDX_W-1:0] rr_ptr_q;    // First port to look at
  logic [IDX_W-1:0] sel_q;       // Port held while locked
  logic [IDX_W-1:0] sel;
  logic [IDX_W-1:0] search_idx;
  logic             search_hit;
  logic             grant;

  // ------------------------------------------------------------------
  // Rotating-priority search, starting at rr_ptr_q
  // ------------------------------------------------------------------
  always_comb begin
    int unsigned cand;
    search_hit = 1'b0;
    search_idx = '0;
    for (int unsigned k = 0; k < NUM_PORTS; k++) begin
      cand = (rr_ptr_q + k) % NUM_PORTS;
      if (!search_hit && slv_aw_valid_i[cand]) begin
        search_hit = 1'b1;
        search_idx = cand[IDX_W-1:0];
      end
    end
  end

  // ------------------------------------------------------------------
  // Issue and lock control
  // ------------------------------------------------------------------
  always_comb begin
    state_d        = state_q;
    sel            = search_idx;
    aw_valid_o     = 1'b0;
    fifo_push_o    = 1'b0;
    slv_aw_ready_o = '0;
    grant          = 1'b0;
    case (state_q)
      AW_IDLE: begin
        if (search_hit && !fifo_full_i) begin
          aw_valid_o  = 1'b1;
          fifo_push_o = 1'b1;           // Push once, on first offer
          if (aw_ready_i) grant = 1'b1;
          else state_d = AW_LOCKED;
        end
      end
      AW_LOCKED: begin
        sel        = sel_q;
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          grant   = 1'b1;
          state_d = AW_IDLE;
        end
      end
      default: state_d = AW_IDLE;
    endcase
    if (grant) slv_aw_ready_o[sel] = 1'b1;
  end

  assign aw_id_o    = {sel, slv_aw_id_i[sel]};  // Port index in the upper bits
  assign aw_addr_o  = slv_aw_addr_i[sel];
  assign fifo_idx_o = sel;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= AW_IDLE;
      rr_ptr_q <= '0;
      sel_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == AW_IDLE) sel_q <= sel;
      if (grant) rr_ptr_q <= (sel == IDX_W'(NUM_PORTS - 1)) ? '0 : sel + 1'b1;
    end
  end

  a_ready_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(slv_aw_ready_o) && ((slv_aw_ready_o & ~slv_aw_valid_i) == '0))
    else $error("AW ready not one-hot or given without valid");

  // A stalled AW keeps its payload and is not pushed a second time
  a_lock_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_id_o) && !fifo_push_o)
    else $error("Stalled AW changed or pushed twice");

endmodule

//--- design/w_route.sv
/* W switch driven by a FIFO of port indices in AW order. Not fall-through:
   a burst can pass from the cycle after its push. Pop on the accepted last beat */
`timescale 1ns/1ps

module w_route import axi_mux_pkg::*; #(
  parameter  int unsigned NUM_PORTS   = 4,
  parameter  int unsigned MAX_W_TRANS = 4,
  localparam int unsigned IDX_W       = $clog2(NUM_PORTS)
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 fifo_push_i,
  input  logic [IDX_W-1:0]                     fifo_idx_i,
  output logic                                 fifo_full_o,
  input  logic [NUM_PORTS-1:0]                 slv_w_valid_i,
  input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] slv_w_data_i,
  input  logic [NUM_PORTS-1:0]                 slv_w_last_i,
  output logic [NUM_PORTS-1:0]                 slv_w_ready_o,
  output logic                                 mst_w_valid_o,
  output logic [DATA_WIDTH-1:0]                mst_w_data_o,
  output logic                                 mst_w_last_o,
  input  logic                                 mst_w_ready_i
);

  localparam int unsigned PTR_W = (MAX_W_TRANS > 1) ? $clog2(MAX_W_TRANS) : 1;
  localparam int unsigned CNT_W = $clog2(MAX_W_TRANS + 1);

  logic [IDX_W-1:0] fifo_mem [MAX_W_TRANS];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [IDX_W-1:0] head_idx;
  logic             fifo_empty;
  logic             fifo_pop;

  assign fifo_empty  = (count_q == '0);
  assign fifo_full_o = (count_q == CNT_W'(MAX_W_TRANS));
  assign head_idx    = fifo_mem[rd_ptr_q];

  // ------------------------------------------------------------------
  // W multiplexer, follows the FIFO head
  // ------------------------------------------------------------------
  always_comb begin
    mst_w_valid_o = 1'b0;
    slv_w_ready_o = '0;
    fifo_pop      = 1'b0;
    if (!fifo_empty) begin
      mst_w_valid_o           = slv_w_valid_i[head_idx];
      slv_w_ready_o[head_idx] = mst_w_ready_i;
      fifo_pop = slv_w_valid_i[head_idx] & mst_w_ready_i & slv_w_last_i[head_idx];
    end
  end

  assign mst_w_data_o = slv_w_data_i[head_idx];
  assign mst_w_last_o = slv_w_last_i[head_idx];

  // ------------------------------------------------------------------
  // Index FIFO
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (fifo_push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_W_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_W_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (fifo_push_i && !fifo_pop) count_q <= count_q + 1'b1;
      else if (!fifo_push_i && fifo_pop) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_push_i) fifo_mem[wr_ptr_q] <= fifo_idx_i;
  end

  // Arbiter must respect full; W must not run ahead of its AW
  a_fifo_bounds : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(fifo_pop && fifo_empty) && !(fifo_push_i && fifo_full_o))
    else $error("W route FIFO overflow or underflow");

endmodule

//--- design/b_route.sv
/* B return path. Responses are registered, then steered to the port named by
   the upper ID bits; ID and response are shared by all ports */
`timescale 1ns/1ps

module b_route import axi_mux_pkg::*; #(
  parameter  int unsigned NUM_PORTS = 4,
  localparam int unsigned IDX_W     = $clog2(NUM_PORTS),
  localparam int unsigned MST_ID_W  = SLV_ID_WIDTH + IDX_W
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    mst_b_valid_i,
  output logic                    mst_b_ready_o,
  input  logic [MST_ID_W-1:0]     mst_b_id_i,
  input  axi_resp_e               mst_b_resp_i,
  output logic [NUM_PORTS-1:0]    slv_b_valid_o,
  input  logic [NUM_PORTS-1:0]    slv_b_ready_i,
  output logic [SLV_ID_WIDTH-1:0] slv_b_id_o,
  output axi_resp_e               slv_b_resp_o
);

  logic                b_valid;
  logic [MST_ID_W-1:0] b_id;
  logic [1:0]          b_resp;
  logic [IDX_W-1:0]    b_port;

  spill_register #(
    .WIDTH    ( MST_ID_W + 2 )
  ) b_spill_inst (
    .clk_i    ( clk_i                        ),
    .arst_n_i ( arst_n_i                     ),
    .valid_i  ( mst_b_valid_i                ),
    .ready_o  ( mst_b_ready_o                ),
    .data_i   ( {mst_b_id_i, mst_b_resp_i}   ),
    .valid_o  ( b_valid                      ),
    .ready_i  ( slv_b_ready_i[b_port]        ),  // Only the target port completes
    .data_o   ( {b_id, b_resp}               )
  );

  assign b_port        = b_id[MST_ID_W-1 -: IDX_W];
  assign slv_b_valid_o = b_valid ? (NUM_PORTS'(1) << b_port) : '0;
  assign slv_b_id_o    = b_id[SLV_ID_WIDTH-1:0];  // Port bits stripped
  assign slv_b_resp_o  = axi_resp_e'(b_resp);

  // A registered response must land on exactly one existing port
  a_b_valid_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid |-> $onehot(slv_b_valid_o))
    else $error("B valid not raised at exactly one port");

endmodule

//--- design/axi_mux_wr.sv
/* Write half of an AXI mux, NUM_PORTS >= 2 upstream ports to one master.
   Master ID is the upstream ID with the port index prepended */
`timescale 1ns/1ps

module axi_mux_wr import axi_mux_pkg::*; #(
  parameter  int unsigned NUM_PORTS   = 4,
  parameter  int unsigned MAX_W_TRANS = 4,   // Outstanding AWs awaiting W
  localparam int unsigned IDX_W       = $clog2(NUM_PORTS),
  localparam int unsigned MST_ID_W    = SLV_ID_WIDTH + IDX_W
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  // Upstream ports
  input  logic [NUM_PORTS-1:0]                   slv_aw_valid_i,
  input  logic [NUM_PORTS-1:0][SLV_ID_WIDTH-1:0] slv_aw_id_i,
  input  logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0]   slv_aw_addr_i,
  output logic [NUM_PORTS-1:0]                   slv_aw_ready_o,
  input  logic [NUM_PORTS-1:0]                   slv_w_valid_i,
  input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]   slv_w_data_i,
  input  logic [NUM_PORTS-1:0]                   slv_w_last_i,
  output logic [NUM_PORTS-1:0]                   slv_w_ready_o,
  output logic [NUM_PORTS-1:0]                   slv_b_valid_o,
  input  logic [NUM_PORTS-1:0]                   slv_b_ready_i,
  output logic [SLV_ID_WIDTH-1:0]                slv_b_id_o,
  output axi_resp_e                              slv_b_resp_o,
  // Master port
  output logic                                   mst_aw_valid_o,
  input  logic                                   mst_aw_ready_i,
  output logic [MST_ID_W-1:0]                    mst_aw_id_o,
  output logic [ADDR_WIDTH-1:0]                  mst_aw_addr_o,
  output logic                                   mst_w_valid_o,
  output logic [DATA_WIDTH-1:0]                  mst_w_data_o,
  output logic                                   mst_w_last_o,
  input  logic                                   mst_w_ready_i,
  input  logic                                   mst_b_valid_i,
  output logic                                   mst_b_ready_o,
  input  logic [MST_ID_W-1:0]                    mst_b_id_i,
  input  axi_resp_e                              mst_b_resp_i
);

  logic                  aw_valid, aw_ready;
  logic [MST_ID_W-1:0]   aw_id;
  logic [ADDR_WIDTH-1:0] aw_addr;
  logic                  fifo_full, fifo_push;
  logic [IDX_W-1:0]      fifo_idx;

  // ------------------------------------------------------------------
  // AW path
  // ------------------------------------------------------------------
  aw_arbiter #(
    .NUM_PORTS      ( NUM_PORTS      )
  ) aw_arbiter_inst (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_id_i    ( slv_aw_id_i    ),
    .slv_aw_addr_i  ( slv_aw_addr_i  ),
    .slv_aw_ready_o ( slv_aw_ready_o ),
    .aw_valid_o     ( aw_valid       ),
    .aw_ready_i     ( aw_ready       ),
    .aw_id_o        ( aw_id          ),
    .aw_addr_o      ( aw_addr        ),
    .fifo_full_i    ( fifo_full      ),
    .fifo_push_o    ( fifo_push      ),
    .fifo_idx_o     ( fifo_idx       )
  );

  spill_register #(
    .WIDTH    ( MST_ID_W + ADDR_WIDTH          )
  ) aw_spill_inst (
    .clk_i    ( clk_i                          ),
    .arst_n_i ( arst_n_i                       ),
    .valid_i  ( aw_valid                       ),
    .ready_o  ( aw_ready                       ),
    .data_i   ( {aw_id, aw_addr}               ),
    .valid_o  ( mst_aw_valid_o                 ),
    .ready_i  ( mst_aw_ready_i                 ),
    .data_o   ( {mst_aw_id_o, mst_aw_addr_o}   )
  );

  // ------------------------------------------------------------------
  // W and B paths
  // ------------------------------------------------------------------
  w_route #(
    .NUM_PORTS     ( NUM_PORTS     ),
    .MAX_W_TRANS   ( MAX_W_TRANS   )
  ) w_route_inst (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .fifo_push_i   ( fifo_push     ),
    .fifo_idx_i    ( fifo_idx      ),
    .fifo_full_o   ( fifo_full     ),
    .slv_w_valid_i ( slv_w_valid_i ),
    .slv_w_data_i  ( slv_w_data_i  ),
    .slv_w_last_i  ( slv_w_last_i  ),
    .slv_w_ready_o ( slv_w_ready_o ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_data_o  ( mst_w_data_o  ),
    .mst_w_last_o  ( mst_w_last_o  ),
    .mst_w_ready_i ( mst_w_ready_i )
  );

  b_route #(
    .NUM_PORTS     ( NUM_PORTS     )
  ) b_route_inst (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .mst_b_valid_i ( mst_b_valid_i ),
    .mst_b_ready_o ( mst_b_ready_o ),
    .mst_b_id_i    ( mst_b_id_i    ),
    .mst_b_resp_i  ( mst_b_resp_i  ),
    .slv_b_valid_o ( slv_b_valid_o ),
    .slv_b_ready_i ( slv_b_ready_i ),
    .slv_b_id_o    ( slv_b_id_o    ),
    .slv_b_resp_o  ( slv_b_resp_o  )
  );

endmodule

//--- test/tb_axi_mux_wr.sv
/* Bench for the 4-port write mux with MAX_W_TRANS 4. The slave model answers
   in AW order and takes W only for AWs it has already seen */
`timescale 1ns/1ps

module tb_axi_mux_wr import axi_mux_pkg::*; ();

  localparam int unsigned NUM_PORTS   = 4;
  localparam int unsigned MAX_W_TRANS = 4;
  localparam int unsigned IDX_W       = 2;
  localparam int unsigned MST_ID_W    = SLV_ID_WIDTH + IDX_W;
  localparam int          NUM_TXN     = 8;

  typedef struct packed {
    logic [IDX_W-1:0]        port;
    logic [SLV_ID_WIDTH-1:0] id;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [3:0]              beats;
    logic [DATA_WIDTH-1:0]   data;   // Beat b carries data + b
    axi_resp_e               resp;
  } txn_t;

  // Port, ID, address, beats, first data word, response
  txn_t txn_tab [NUM_TXN] = '{
    '{2'd0, 4'h3, 32'h1000_0000, 4'd2, 32'ha000_0000, RESP_OKAY},
    '{2'd1, 4'h5, 32'h1000_0100, 4'd1, 32'hb100_0000, RESP_SLVERR},
    '{2'd2, 4'h3, 32'h2000_0200, 4'd4, 32'hc200_0000, RESP_OKAY},
    '{2'd3, 4'hf, 32'h3000_0300, 4'd3, 32'hd300_0000, RESP_EXOKAY},
    '{2'd0, 4'h7, 32'h4000_0040, 4'd1, 32'ha040_0000, RESP_DECERR},
    '{2'd1, 4'h5, 32'h5000_0140, 4'd2, 32'hb140_0000, RESP_OKAY},
    '{2'd2, 4'h0, 32'h6000_0240, 4'd3, 32'hc240_0000, RESP_SLVERR},
    '{2'd3, 4'ha, 32'h7000_0340, 4'd2, 32'hd340_0000, RESP_OKAY}
  };

  logic                                   clk, arst_n;
  logic [NUM_PORTS-1:0]                   slv_aw_valid, slv_aw_ready;
  logic [NUM_PORTS-1:0][SLV_ID_WIDTH-1:0] slv_aw_id;
  logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0]   slv_aw_addr;
  logic [NUM_PORTS-1:0]                   slv_w_valid, slv_w_last, slv_w_ready;
  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]   slv_w_data;
  logic [NUM_PORTS-1:0]                   slv_b_valid, slv_b_ready;
  logic [SLV_ID_WIDTH-1:0]                slv_b_id;
  axi_resp_e                              slv_b_resp, mst_b_resp;
  logic                                   mst_aw_valid, mst_aw_ready, mst_w_valid;
  logic                                   mst_w_last, mst_w_ready, mst_b_valid, mst_b_ready;
  logic [MST_ID_W-1:0]                    mst_aw_id, mst_b_id;
  logic [ADDR_WIDTH-1:0]                  mst_aw_addr;
  logic [DATA_WIDTH-1:0]                  mst_w_data;

  int aw_q      [NUM_PORTS][$];  // Not yet accepted upstream
  int w_q       [NUM_PORTS][$];  // Accepted, W still due
  int b_q       [NUM_PORTS][$];  // Responses due at this port, in AW order
  int port_list [NUM_PORTS][$];
  int beat      [NUM_PORTS];
  int mst_aw_seen [NUM_PORTS];
  int mst_w_q[$];
  int mst_b_q[$];
  int mst_beat;
  int mst_aw_cnt = 0;
  int done_cnt   = 0;
  int seed       = 32'hbd71_b0f3;
  logic [MST_ID_W-1:0] rx_id [NUM_TXN];
  logic w_release, stall_en;

  axi_mux_wr #(
    .NUM_PORTS      ( NUM_PORTS    ),
    .MAX_W_TRANS    ( MAX_W_TRANS  )
  ) axi_mux_wr_inst (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .slv_aw_valid_i ( slv_aw_valid ),
    .slv_aw_id_i    ( slv_aw_id    ),
    .slv_aw_addr_i  ( slv_aw_addr  ),
    .slv_aw_ready_o ( slv_aw_ready ),
    .slv_w_valid_i  ( slv_w_valid  ),
    .slv_w_data_i   ( slv_w_data   ),
    .slv_w_last_i   ( slv_w_last   ),
    .slv_w_ready_o  ( slv_w_ready  ),
    .slv_b_valid_o  ( slv_b_valid  ),
    .slv_b_ready_i  ( slv_b_ready  ),
    .slv_b_id_o     ( slv_b_id     ),
    .slv_b_resp_o   ( slv_b_resp   ),
    .mst_aw_valid_o ( mst_aw_valid ),
    .mst_aw_ready_i ( mst_aw_ready ),
    .mst_aw_id_o    ( mst_aw_id    ),
    .mst_aw_addr_o  ( mst_aw_addr  ),
    .mst_w_valid_o  ( mst_w_valid  ),
    .mst_w_data_o   ( mst_w_data   ),
    .mst_w_last_o   ( mst_w_last   ),
    .mst_w_ready_i  ( mst_w_ready  ),
    .mst_b_valid_i  ( mst_b_valid  ),
    .mst_b_ready_o  ( mst_b_ready  ),
    .mst_b_id_i     ( mst_b_id     ),
    .mst_b_resp_i   ( mst_b_resp   )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      stop_run($sformatf("Error: %s expected 0x%0h actual 0x%0h", name, exp, act));
    end
  endtask

  // ------------------------------------------------------------------
  // Round robin and back-pressure first and random stalls after
  // ------------------------------------------------------------------
  initial begin : main_seq
    arst_n    = 1'b0;
    w_release = 1'b0;  // W held back so the index FIFO fills
    stall_en  = 1'b0;
    for (int t = 0; t < NUM_TXN; t++) begin
      aw_q[txn_tab[t].port].push_back(t);
      port_list[txn_tab[t].port].push_back(t);
    end
    repeat (16) @(posedge clk);
    #1 arst_n = 1'b1;
    wait (mst_aw_cnt == MAX_W_TRANS);
    repeat (20) begin
      @(posedge clk);
      #2;
      check_val("upstream AW ready with FIFO full", 0, 32'(slv_aw_ready));
    end
    check_val("AWs at master with W withheld", MAX_W_TRANS, mst_aw_cnt);
    w_release = 1'b1;
    stall_en  = 1'b1;
    wait (done_cnt == NUM_TXN);
    repeat (10) @(posedge clk);
    #2;  // A stray AW or W beat would still be offered here
    check_val("master AW valid after the last write", 0, 32'(mst_aw_valid));
    check_val("master W valid after the last write", 0, 32'(mst_w_valid));
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin : watchdog
    repeat (16 + NUM_TXN * 200) @(posedge clk);
    stop_run("Timeout: the writes did not all complete in time");
  end

  // Upstream masters drive after the edge and sample handshakes at the negedge
  initial begin : upstream_ports
    int t;
    slv_aw_valid = '0;
    slv_aw_id    = '0;
    slv_aw_addr  = '0;
    slv_w_valid  = '0;
    slv_w_data   = '0;
    slv_w_last   = '0;
    slv_b_ready  = '0;
    for (int p = 0; p < NUM_PORTS; p++) beat[p] = 0;
    wait (arst_n);
    forever begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        slv_aw_valid[p] = (aw_q[p].size() > 0);
        if (aw_q[p].size() > 0) begin
          slv_aw_id[p]   = txn_tab[aw_q[p][0]].id;
          slv_aw_addr[p] = txn_tab[aw_q[p][0]].addr;
        end
        slv_w_valid[p] = w_release && (w_q[p].size() > 0);
        if (w_q[p].size() > 0) begin
          t = w_q[p][0];
          slv_w_data[p] = txn_tab[t].data + DATA_WIDTH'(beat[p]);
          slv_w_last[p] = (beat[p] == int'(txn_tab[t].beats) - 1);
        end
        slv_b_ready[p] = 1'b1;
      end
      @(negedge clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (slv_aw_valid[p] && slv_aw_ready[p]) begin
          t = aw_q[p].pop_front();
          w_q[p].push_back(t);
          b_q[p].push_back(t);
        end
        if (slv_w_valid[p] && slv_w_ready[p]) begin
          if (slv_w_last[p]) begin
            void'(w_q[p].pop_front());
            beat[p] = 0;
          end else begin
            beat[p]++;
          end
        end
        if (slv_b_valid[p] && slv_b_ready[p]) begin
          if (b_q[p].size() == 0) begin
            stop_run($sformatf("A response reached port %0d with no write outstanding", p));
          end
          t = b_q[p].pop_front();
          check_val($sformatf("B ID at port %0d", p), 32'(txn_tab[t].id), 32'(slv_b_id));
          check_val($sformatf("B resp at port %0d", p), 32'(txn_tab[t].resp),
                    32'(slv_b_resp));
          done_cnt++;
        end
      end
      @(posedge clk);
      #1;
    end
  end

  // Downstream slave model with random stalls once stall_en is set
  initial begin : slave_model
    int t;
    int p;
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    mst_b_valid  = 1'b0;
    mst_b_id     = '0;
    mst_b_resp   = RESP_OKAY;
    mst_beat     = 0;
    for (int k = 0; k < NUM_PORTS; k++) mst_aw_seen[k] = 0;
    wait (arst_n);
    forever begin
      mst_aw_ready = !stall_en || (($random(seed) & 3) != 0);
      mst_w_ready  = (mst_w_q.size() > 0) && (!stall_en || (($random(seed) & 3) != 0));
      mst_b_valid  = (mst_b_q.size() > 0);
      if (mst_b_q.size() > 0) begin
        mst_b_id   = rx_id[mst_b_q[0]];
        mst_b_resp = txn_tab[mst_b_q[0]].resp;
      end
      @(negedge clk);
      if (mst_aw_valid && mst_aw_ready) begin
        p = int'(mst_aw_id[MST_ID_W-1 -: IDX_W]);
        if (mst_aw_seen[p] >= port_list[p].size()) begin
          stop_run($sformatf("The master issued an extra AW for port %0d", p));
        end
        t = port_list[p][mst_aw_seen[p]];
        mst_aw_seen[p]++;
        if (mst_aw_cnt < NUM_PORTS) check_val("round-robin source port", mst_aw_cnt, p);
        check_val("AW ID low bits", 32'(txn_tab[t].id), 32'(mst_aw_id[SLV_ID_WIDTH-1:0]));
        check_val("AW address", txn_tab[t].addr, mst_aw_addr);
        rx_id[t] = mst_aw_id;
        mst_w_q.push_back(t);
        mst_aw_cnt++;
      end
      if (mst_w_valid && mst_w_ready) begin
        t = mst_w_q[0];
        check_val("W data", txn_tab[t].data + DATA_WIDTH'(mst_beat), mst_w_data);
        check_val("W last", 32'(mst_beat == int'(txn_tab[t].beats) - 1), 32'(mst_w_last));
        if (mst_w_last) begin
          void'(mst_w_q.pop_front());
          mst_b_q.push_back(t);
          mst_beat = 0;
        end else begin
          mst_beat++;
        end
      end
      if (mst_b_valid && mst_b_ready) void'(mst_b_q.pop_front());
      @(posedge clk);
      #1;
    end
  end

endmodule

//--- flist.f
common/axi_mux_pkg.sv
design/spill_register.sv
design/aw_arbiter.sv
design/w_route.sv
design/b_route.sv
design/axi_mux_wr.sv
test/tb_axi_mux_wr.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_mux_wr
RTL_TOP   ?= axi_mux_wr
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_STR  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
